/* Bender.yml */
package:
  name: skiroc_daq

sources:
  - daq_pkg.sv
  - power_on_reset.sv
  - cmd_regs.sv
  - byte_fifo.sv
  - sc_frame_builder.sv
  - sc_shifter.sv
  - hv_cmd_builder.sv
  - hv_uart_tx.sv
  - daq_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - daq_tb.sv

/* byte_fifo.sv */
// Synchronous byte FIFO with occupancy count and registered read port
`timescale 1ns/10ps
`default_nettype none

module byte_fifo #(
	parameter int DEPTH = 16                           // Power of two
) (
	input  wire        Clk_Out_2_All,
	input  wire        rst_n_i,
	input  wire        wr_en_i,
	input  wire  [7:0] wr_data_i,
	input  wire        rd_en_i,
	output logic [7:0] rd_data_o,
	output logic       empty_o,
	output logic       full_o
);

	logic [7:0]               mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;                  // Wraps naturally
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0]   count;
	logic                     do_wr;
	logic                     do_rd;

	assign do_wr   = wr_en_i & ~full_o;
	assign do_rd   = rd_en_i & ~empty_o;
	assign empty_o = (count == 0);
	assign full_o  = (count == DEPTH);

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data_i;
		if (do_rd)
			rd_data_o <= mem[rd_ptr];                    // Valid the cycle after rd_en
	end

endmodule

`default_nettype wire

/* cmd_regs.sv */
// APB register file holding SC and HV settings, status readback and start pulses
`timescale 1ns/10ps
`default_nettype none

module cmd_regs (
	input  wire               Clk_Out_2_All,
	input  wire               rst_n_i,
	input  wire daq_pkg::apb_req_t apb_req_i,
	input  wire               sc_busy_i,
	input  wire               hv_busy_i,
	output daq_pkg::apb_rsp_t apb_rsp_o,
	output daq_pkg::sc_cfg_t  sc_cfg_o,
	output daq_pkg::hv_set_t  hv_set_o,
	output logic              sc_start_o,
	output logic              hv_start_o
);
	import daq_pkg::*;

	sc_cfg_t           cfg_q;
	hv_set_t           hv_q;
	logic              access;
	logic              bad_addr;
	logic              wr_acc;
	logic [APB_DW-1:0] rd_data;

	assign access   = apb_req_i.psel & apb_req_i.penable;        // Access phase
	assign bad_addr = (apb_req_i.paddr > REG_HV) |
		(apb_req_i.pwrite & (apb_req_i.paddr == REG_STATUS));    // STATUS is read only
	assign wr_acc   = access & apb_req_i.pwrite & ~bad_addr;

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			cfg_q      <= '0;                                        // Spare bits stay zero
			hv_q       <= '0;
			sc_start_o <= 1'b0;
			hv_start_o <= 1'b0;
		end
		else
		begin
			sc_start_o <= 1'b0;                                      // Single-cycle pulses
			hv_start_o <= 1'b0;
			if (wr_acc)
			begin
				case (apb_req_i.paddr)
					REG_CTRL:
					begin
						sc_start_o <= apb_req_i.pwdata[0] & ~sc_busy_i;  // Dropped while busy
						hv_start_o <= apb_req_i.pwdata[1] & ~hv_busy_i;
					end
					REG_DAC_GAIN: cfg_q.dac_gain      <= apb_req_i.pwdata[9:0];
					REG_DAC_TRIG: cfg_q.dac_trig      <= apb_req_i.pwdata[9:0];
					REG_MASK0:    cfg_q.mask[15:0]    <= apb_req_i.pwdata;
					REG_MASK1:    cfg_q.mask[31:16]   <= apb_req_i.pwdata;
					REG_MASK2:    cfg_q.mask[47:32]   <= apb_req_i.pwdata;
					REG_MASK3:    cfg_q.mask[63:48]   <= apb_req_i.pwdata;
					REG_MISC:
					begin
						cfg_q.fb_cap       <= apb_req_i.pwdata[3:0];
						cfg_q.delay_trig   <= apb_req_i.pwdata[11:4];
						cfg_q.only_ex_trig <= apb_req_i.pwdata[12];
						cfg_q.tdc_on       <= apb_req_i.pwdata[13];
						cfg_q.val_evt      <= apb_req_i.pwdata[14];
						cfg_q.main_backup  <= apb_req_i.pwdata[15];
					end
					REG_HV:       hv_q <= apb_req_i.pwdata;             // Digit 3 in bits 15:12
					default:      ;
				endcase
			end
		end
	end

	// Read mux, valid in the access phase
	always_comb
	begin
		case (apb_req_i.paddr)
			REG_STATUS:   rd_data = {14'h0, hv_busy_i, sc_busy_i};
			REG_DAC_GAIN: rd_data = {6'h0, cfg_q.dac_gain};
			REG_DAC_TRIG: rd_data = {6'h0, cfg_q.dac_trig};
			REG_MASK0:    rd_data = cfg_q.mask[15:0];
			REG_MASK1:    rd_data = cfg_q.mask[31:16];
			REG_MASK2:    rd_data = cfg_q.mask[47:32];
			REG_MASK3:    rd_data = cfg_q.mask[63:48];
			REG_MISC:     rd_data = {cfg_q.main_backup, cfg_q.val_evt, cfg_q.tdc_on,
				cfg_q.only_ex_trig, cfg_q.delay_trig, cfg_q.fb_cap};
			REG_HV:       rd_data = hv_q;
			default:      rd_data = '0;                             // CTRL reads zero
		endcase
	end

	always_comb
	begin
		apb_rsp_o.prdata  = access ? rd_data : '0;
		apb_rsp_o.pready  = access;                                 // No wait states
		apb_rsp_o.pslverr = access & bad_addr;
	end

	assign sc_cfg_o = cfg_q;
	assign hv_set_o = hv_q;

endmodule

`default_nettype wire

/* daq_pkg.sv */
// Shared localparams, APB register map and packed struct types of the readout core
`default_nettype none

package daq_pkg;

	////////////////////
	// Sizes and timing
	localparam int APB_AW     = 4;            // APB address bits
	localparam int APB_DW     = 16;           // Same width as the old command word
	localparam int POR_CYCLES = 32;           // Short for simulation, raise on board
	localparam int SR_HALF    = 2;            // Half period of sr_ck
	localparam int BAUD_DIV   = 8;            // Cycles per UART bit
	localparam logic [7:0] CHIP_ID = 8'd1;    // Leads the SC frame
	localparam int SC_BITS    = 112;          // CHIP_ID + config
	localparam int SC_BYTES   = 14;
	localparam int HV_BYTES   = 7;            // "HBV" + four digits
	localparam int FIFO_DEPTH = 16;

	////////////////////
	// Register map
	localparam logic [APB_AW-1:0] REG_CTRL     = 4'd0;   // Start bits, write only
	localparam logic [APB_AW-1:0] REG_STATUS   = 4'd1;   // Busy flags, read only
	localparam logic [APB_AW-1:0] REG_DAC_GAIN = 4'd2;
	localparam logic [APB_AW-1:0] REG_DAC_TRIG = 4'd3;
	localparam logic [APB_AW-1:0] REG_MASK0    = 4'd4;   // Mask 15:0
	localparam logic [APB_AW-1:0] REG_MASK1    = 4'd5;
	localparam logic [APB_AW-1:0] REG_MASK2    = 4'd6;
	localparam logic [APB_AW-1:0] REG_MASK3    = 4'd7;   // Mask 63:48
	localparam logic [APB_AW-1:0] REG_MISC     = 4'd8;
	localparam logic [APB_AW-1:0] REG_HV       = 4'd9;   // Highest mapped address

	////////////////////
	// Types
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic [9:0]  dac_gain;
		logic [9:0]  dac_trig;
		logic [63:0] mask;
		logic [3:0]  fb_cap;                   // Feedback capacitance
		logic [7:0]  delay_trig;
		logic        only_ex_trig;
		logic        tdc_on;
		logic        val_evt;
		logic        main_backup;
		logic [3:0]  spare;                    // Always zero
	} sc_cfg_t;

	typedef struct packed {
		logic [3:0] dig3;                      // Sent first
		logic [3:0] dig2;
		logic [3:0] dig1;
		logic [3:0] dig0;
	} hv_set_t;

endpackage

`default_nettype wire

/* daq_tb.sv */
// Directed testbench of the readout core: clock, DUT, APB tasks, checks, tests and timeout
`timescale 1ns/10ps
`default_nettype none

module daq_tb;
	import daq_pkg::*;

	localparam int FRAME_CYC      = SC_BITS*2*SR_HALF + SC_BYTES*4;    // Bits plus FIFO gaps
	localparam int HV_CYC         = HV_BYTES*(10*BAUD_DIV + 2);        // Frames plus idle cycle
	localparam int APB_CYC        = 400;                               // Register traffic
	localparam int TIMEOUT_CYCLES = 2*(POR_CYCLES + 2*FRAME_CYC + 2*HV_CYC + APB_CYC);

	logic         Clk_Out_2_All;
	logic         rst_n_i;
	apb_req_t     apb_req;
	apb_rsp_t     apb_rsp;
	logic         sr_ck;
	logic         sr_in;
	logic         sr_rstb;
	logic         hv_tx;
	logic         sr_bits [$];                       // sr_in at each sr_ck rise
	logic [7:0]   hv_rx [$];                         // Decoded UART bytes
	logic [111:0] exp_frame;                         // CHIP_ID + config, MSB first
	int           cycle_cnt = 0;

	tb_clk_gen u_clk (.clk_o(Clk_Out_2_All));

	daq_top u_dut (
		.Clk_Out_2_All(Clk_Out_2_All),
		.rst_n_i      (rst_n_i),
		.apb_req_i    (apb_req),
		.apb_rsp_o    (apb_rsp),
		.sr_ck_o      (sr_ck),
		.sr_in_o      (sr_in),
		.sr_rstb_o    (sr_rstb),
		.hv_tx_o      (hv_tx)
	);

	////////////////////
	// Monitors
	always @(posedge sr_ck)
		sr_bits.push_back(sr_in);                    // ASIC latches on rising edge

	always @(posedge Clk_Out_2_All)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$fatal(1, "Run aborted on timeout");
		end
	end

	////////////////////
	// Helpers
	task automatic check_eq(input logic [127:0] act, input logic [127:0] exp, input string what);
		if (act !== exp)
		begin
			$display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, what, act, exp);
			$display("sim failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
		input logic [APB_DW-1:0] wdata, input logic exp_err, output logic [APB_DW-1:0] rdata);
		@(posedge Clk_Out_2_All);
		apb_req.psel    <= 1'b1;                     // Setup phase
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge Clk_Out_2_All);
		apb_req.penable <= 1'b1;                     // Access phase
		@(negedge Clk_Out_2_All);
		rdata = apb_rsp.prdata;
		check_eq(apb_rsp.pready, 1'b1, "pready in access phase");
		check_eq(apb_rsp.pslverr, exp_err, "pslverr");
		@(posedge Clk_Out_2_All);
		apb_req.psel    <= 1'b0;                     // Access edge
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
		input logic exp_err);
		logic [APB_DW-1:0] unused;
		apb_xfer(1'b1, addr, data, exp_err, unused);
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
		input logic exp_err);
		apb_xfer(1'b0, addr, '0, exp_err, data);
	endtask

	task automatic wait_status_clear(input int bit_idx);
		logic [APB_DW-1:0] st;
		apb_read(REG_STATUS, st, 1'b0);
		while (st[bit_idx])
			apb_read(REG_STATUS, st, 1'b0);          // Global timeout bounds this
	endtask

	function automatic logic [7:0] hv_ascii_expected(input logic [15:0] hv, input int idx);
		string      prefix     = "HBV";
		string      hex_digits = "0123456789ABCDEF";
		logic [3:0] dig;
		if (idx < 3)
			return prefix[idx];
		dig = hv[15 - 4*(idx - 3) -: 4];             // Most significant digit first
		return hex_digits[dig];
	endfunction

	task automatic uart_get_byte(output logic [7:0] data);
		logic start_b;
		logic stop_b;
		@(negedge Clk_Out_2_All);
		while (hv_tx !== 1'b0)
			@(negedge Clk_Out_2_All);                // Hunt for start bit
		repeat (BAUD_DIV/2 - 1)
			@(negedge Clk_Out_2_All);
		start_b = hv_tx;                             // Mid start bit
		for (int i = 0; i < 8; i++)
		begin
			repeat (BAUD_DIV)
				@(negedge Clk_Out_2_All);
			data[i] = hv_tx;                         // LSB first
		end
		repeat (BAUD_DIV)
			@(negedge Clk_Out_2_All);
		stop_b = hv_tx;
		check_eq(start_b, 1'b0, "UART start bit");
		check_eq(stop_b, 1'b1, "UART stop bit");
	endtask

	task automatic receive_hv_cmd();
		logic [7:0] b;
		hv_rx.delete();
		repeat (HV_BYTES)
		begin
			uart_get_byte(b);
			hv_rx.push_back(b);
		end
	endtask

	task automatic check_hv_cmd(input logic [15:0] hv);
		for (int i = 0; i < HV_BYTES; i++)
			check_eq(hv_rx[i], hv_ascii_expected(hv, i), "HV command byte");
	endtask

	task automatic check_sc_bits(input logic [111:0] exp);
		logic [111:0] got;
		check_eq(sr_bits.size(), SC_BITS, "sr_ck rising edges");
		for (int i = 0; i < SC_BITS; i++)
			got[SC_BITS-1-i] = sr_bits[i];
		check_eq(got, exp, "SC bitstream");
	endtask

	task automatic write_random_cfg(output logic [111:0] frame);
		logic [15:0] gain;
		logic [15:0] trig;
		logic [15:0] misc;
		logic [63:0] mask;
		gain = $urandom();
		trig = $urandom();
		misc = $urandom();
		mask = {$urandom(), $urandom()};
		apb_write(REG_DAC_GAIN, gain, 1'b0);
		apb_write(REG_DAC_TRIG, trig, 1'b0);
		apb_write(REG_MASK0, mask[15:0], 1'b0);
		apb_write(REG_MASK1, mask[31:16], 1'b0);
		apb_write(REG_MASK2, mask[47:32], 1'b0);
		apb_write(REG_MASK3, mask[63:48], 1'b0);
		apb_write(REG_MISC, misc, 1'b0);
		// Single flags go out in struct order, the reverse of the MISC word
		frame = {CHIP_ID, gain[9:0], trig[9:0], mask, misc[3:0], misc[11:4],
			misc[12], misc[13], misc[14], misc[15], 4'h0};
	endtask

	////////////////////
	// Tests
	task automatic test_reset_state();
		logic [APB_DW-1:0] wd;
		logic [APB_DW-1:0] rd;
		logic [APB_DW-1:0] mask;
		check_eq(sr_ck, 1'b0, "sr_ck after reset");
		check_eq(sr_in, 1'b0, "sr_in after reset");
		check_eq(hv_tx, 1'b1, "hv_tx idle after reset");
		apb_read(REG_STATUS, rd, 1'b0);
		check_eq(rd, 16'h0, "STATUS after reset");
		for (int a = REG_DAC_GAIN; a <= REG_HV; a++)
		begin
			mask = (a <= REG_DAC_TRIG) ? 16'h03FF : 16'hFFFF;   // DAC fields are 10 bits
			wd   = $urandom();
			apb_read(4'(a), rd, 1'b0);
			check_eq(rd, 16'h0, "register reset value");
			apb_write(4'(a), wd, 1'b0);
			apb_read(4'(a), rd, 1'b0);
			check_eq(rd, wd & mask, "register readback");
		end
	endtask

	task automatic test_unmapped();
		logic [APB_DW-1:0] rd;
		apb_read(4'd12, rd, 1'b1);
		apb_write(4'd12, 16'h5A5A, 1'b1);
		apb_write(REG_STATUS, 16'h0003, 1'b1);       // Read only
		apb_read(REG_HV, rd, 1'b0);
		apb_write(REG_DAC_TRIG, 16'h0155, 1'b0);
		apb_read(REG_STATUS, rd, 1'b0);
		check_eq(rd, 16'h0, "STATUS after rejected write");
	endtask

	task automatic test_sc_bitstream();
		logic [APB_DW-1:0] rd;
		write_random_cfg(exp_frame);
		sr_bits.delete();
		apb_write(REG_CTRL, 16'h0001, 1'b0);
		apb_read(REG_STATUS, rd, 1'b0);
		check_eq(rd[0], 1'b1, "sc_busy during shift");
		wait_status_clear(0);
		check_sc_bits(exp_frame);
		check_eq(sr_ck, 1'b0, "sr_ck idle after frame");
		check_eq(sr_in, 1'b0, "sr_in idle after frame");
	endtask

	task automatic test_hv_cmd();
		logic [APB_DW-1:0] hv;
		logic [APB_DW-1:0] rd;
		hv = $urandom();
		apb_write(REG_HV, hv, 1'b0);
		fork
			receive_hv_cmd();
			begin
				apb_write(REG_CTRL, 16'h0002, 1'b0);
				apb_read(REG_STATUS, rd, 1'b0);
				check_eq(rd[1], 1'b1, "hv_busy during command");
			end
		join
		wait_status_clear(1);
		check_hv_cmd(hv);
		check_eq(hv_tx, 1'b1, "hv_tx idle after command");
	endtask

	task automatic test_start_while_busy();
		logic [APB_DW-1:0] hv;
		logic [APB_DW-1:0] rd;
		hv = $urandom();
		apb_write(REG_HV, hv, 1'b0);
		sr_bits.delete();
		apb_write(REG_CTRL, 16'h0001, 1'b0);         // Config kept from previous frame
		fork
			receive_hv_cmd();
			begin
				apb_read(REG_STATUS, rd, 1'b0);
				check_eq(rd[0], 1'b1, "sc_busy before second start");
				apb_write(REG_CTRL, 16'h0003, 1'b0);     // SC start dropped, HV runs
				repeat (50)
					@(posedge Clk_Out_2_All);
				apb_write(REG_CTRL, 16'h0001, 1'b0);
				wait_status_clear(0);
			end
		join
		wait_status_clear(1);
		check_sc_bits(exp_frame);
		check_hv_cmd(hv);
		repeat (SC_BYTES*2)
			@(posedge Clk_Out_2_All);
		apb_read(REG_STATUS, rd, 1'b0);
		check_eq(rd, 16'h0, "STATUS idle at end");
		check_eq(sr_bits.size(), SC_BITS, "no extra sr_ck edges");
	endtask

	////////////////////
	// Main sequence
	initial
	begin
		logic [31:0] seed_val;
		int          por_wait;
		rst_n_i  = 1'b0;
		apb_req  = '0;
		seed_val = $urandom(87);                     // Seeds the generator once
		repeat (4)
			@(posedge Clk_Out_2_All);
		rst_n_i  <= 1'b1;
		por_wait = 0;
		@(negedge Clk_Out_2_All);
		while (sr_rstb !== 1'b1)
		begin
			@(negedge Clk_Out_2_All);                // Power-on count and delayed reset
			por_wait++;
		end
		check_eq(por_wait, POR_CYCLES + 2, "cycles from board reset to sr_rstb");
		test_reset_state();
		test_unmapped();
		test_sc_bitstream();
		test_hv_cmd();
		test_start_while_busy();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* daq_top.sv */
// Top level of the SKIROC2 control core: reset, registers, SC path and HV path
`timescale 1ns/10ps
`default_nettype none

module daq_top (
	input  wire                Clk_Out_2_All,
	input  wire                rst_n_i,
	input  wire daq_pkg::apb_req_t apb_req_i,
	output daq_pkg::apb_rsp_t  apb_rsp_o,
	output logic               sr_ck_o,
	output logic               sr_in_o,
	output logic               sr_rstb_o,
	output logic               hv_tx_o
);
	import daq_pkg::*;

	logic       rst_n_int;
	sc_cfg_t    sc_cfg;
	hv_set_t    hv_set;
	logic       sc_start, hv_start;
	logic       sc_busy, hv_busy, sc_done;
	logic       fifo_wr_en, fifo_rd_en, fifo_empty, fifo_full;
	logic [7:0] fifo_wr_data, fifo_rd_data;
	logic       tx_valid, tx_ready;
	logic [7:0] tx_data;

	power_on_reset u_por (.Clk_Out_2_All, .rst_n_i, .rst_n_int_o(rst_n_int));

	assign sr_rstb_o = rst_n_int;                    // ASIC SC register follows internal reset

	cmd_regs u_regs (.Clk_Out_2_All, .rst_n_i(rst_n_int), .apb_req_i, .sc_busy_i(sc_busy),
		.hv_busy_i(hv_busy), .apb_rsp_o, .sc_cfg_o(sc_cfg), .hv_set_o(hv_set),
		.sc_start_o(sc_start), .hv_start_o(hv_start));

	////////////////////
	// Slow-control path
	sc_frame_builder u_frame (.Clk_Out_2_All, .rst_n_i(rst_n_int), .start_i(sc_start),
		.cfg_i(sc_cfg), .done_i(sc_done), .fifo_full_i(fifo_full),
		.fifo_wr_en_o(fifo_wr_en), .fifo_data_o(fifo_wr_data), .busy_o(sc_busy));

	byte_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (.Clk_Out_2_All, .rst_n_i(rst_n_int),
		.wr_en_i(fifo_wr_en), .wr_data_i(fifo_wr_data), .rd_en_i(fifo_rd_en),
		.rd_data_o(fifo_rd_data), .empty_o(fifo_empty), .full_o(fifo_full));

	sc_shifter u_shift (.Clk_Out_2_All, .rst_n_i(rst_n_int), .fifo_empty_i(fifo_empty),
		.fifo_data_i(fifo_rd_data), .fifo_rd_en_o(fifo_rd_en), .sr_ck_o, .sr_in_o,
		.done_o(sc_done));

	////////////////////
	// HV path
	hv_cmd_builder u_hv_cmd (.Clk_Out_2_All, .rst_n_i(rst_n_int), .start_i(hv_start),
		.hv_set_i(hv_set), .tx_ready_i(tx_ready), .tx_valid_o(tx_valid),
		.tx_data_o(tx_data), .busy_o(hv_busy));

	hv_uart_tx u_hv_tx (.Clk_Out_2_All, .rst_n_i(rst_n_int), .tx_valid_i(tx_valid),
		.tx_data_i(tx_data), .tx_ready_o(tx_ready), .tx_o(hv_tx_o));

endmodule

`default_nettype wire

/* hv_cmd_builder.sv */
// Sends the seven-byte ASCII HV command "HBV" + four hex digits to the UART
`timescale 1ns/10ps
`default_nettype none

module hv_cmd_builder (
	input  wire              Clk_Out_2_All,
	input  wire              rst_n_i,
	input  wire              start_i,
	input  wire daq_pkg::hv_set_t hv_set_i,
	input  wire              tx_ready_i,
	output logic             tx_valid_o,
	output logic [7:0]       tx_data_o,
	output logic             busy_o
);
	import daq_pkg::*;

	hv_set_t    hv_q;
	logic [2:0] idx;                                 // Byte 0 to 6
	logic       draining;                            // Last byte on the line

	function automatic logic [7:0] hex_ascii(input logic [3:0] dig);
		return (dig < 4'd10) ? (8'h30 + {4'h0, dig}) : (8'h37 + {4'h0, dig});  // Upper case
	endfunction

	always_comb
	begin
		case (idx)
			3'd0:    tx_data_o = 8'h48;                  // H
			3'd1:    tx_data_o = 8'h42;                  // B
			3'd2:    tx_data_o = 8'h56;                  // V
			3'd3:    tx_data_o = hex_ascii(hv_q.dig3);
			3'd4:    tx_data_o = hex_ascii(hv_q.dig2);
			3'd5:    tx_data_o = hex_ascii(hv_q.dig1);
			default: tx_data_o = hex_ascii(hv_q.dig0);
		endcase
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			tx_valid_o <= 1'b0;
			busy_o     <= 1'b0;
			draining   <= 1'b0;
			idx        <= '0;
		end
		else if (start_i && !busy_o)
		begin
			tx_valid_o <= 1'b1;
			busy_o     <= 1'b1;
			idx        <= '0;
		end
		else if (tx_valid_o && tx_ready_i)
		begin
			if (idx == HV_BYTES - 1)
			begin
				tx_valid_o <= 1'b0;
				draining   <= 1'b1;
			end
			else
				idx <= idx + 1'b1;
		end
		else if (draining && tx_ready_i)
		begin
			draining <= 1'b0;                          // Seventh stop bit done
			busy_o   <= 1'b0;
		end
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (start_i && !busy_o)
			hv_q <= hv_set_i;
	end

endmodule

`default_nettype wire

/* hv_uart_tx.sv */
// 8N1 serial transmitter towards the HV module, idle high
`timescale 1ns/10ps
`default_nettype none

module hv_uart_tx (
	input  wire        Clk_Out_2_All,
	input  wire        rst_n_i,
	input  wire        tx_valid_i,
	input  wire  [7:0] tx_data_i,
	output logic       tx_ready_o,
	output logic       tx_o
);
	import daq_pkg::*;

	logic [9:0]                  shreg;              // Stop, data, start
	logic [$clog2(BAUD_DIV)-1:0] baud_cnt;
	logic [3:0]                  bit_cnt;            // 10 bits per frame
	logic                        active;

	assign tx_ready_o = ~active;
	assign tx_o       = shreg[0];

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			shreg    <= '1;                            // Line idles high
			baud_cnt <= '0;
			bit_cnt  <= '0;
			active   <= 1'b0;
		end
		else if (!active)
		begin
			if (tx_valid_i)
			begin
				shreg    <= {1'b1, tx_data_i, 1'b0};    // LSB first after start bit
				baud_cnt <= '0;
				bit_cnt  <= '0;
				active   <= 1'b1;
			end
		end
		else
		begin
			baud_cnt <= baud_cnt + 1'b1;
			if (baud_cnt == BAUD_DIV - 1)
			begin
				baud_cnt <= '0;
				shreg    <= {1'b1, shreg[9:1]};
				bit_cnt  <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd9)
					active <= 1'b0;                      // End of stop bit
			end
		end
	end

endmodule

`default_nettype wire

/* power_on_reset.sv */
// Power-on counter with two-flop delayed board reset, giving the internal reset
`timescale 1ns/10ps
`default_nettype none

module power_on_reset (
	input  wire  Clk_Out_2_All,
	input  wire  rst_n_i,
	output logic rst_n_int_o
);
	import daq_pkg::*;

	logic [$clog2(POR_CYCLES + 1) - 1:0] por_cnt = '0;   // Starts at zero on configuration
	logic                                rst_d1  = 1'b0;
	logic                                rst_d2  = 1'b0;
	logic                                por_done;

	assign por_done = (por_cnt == POR_CYCLES);

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
			por_cnt <= '0;                                // Board reset restarts the count
		else if (!por_done)
			por_cnt <= por_cnt + 1'b1;
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!por_done)
		begin
			rst_d1 <= 1'b0;                               // Hold low during power-on
			rst_d2 <= 1'b0;
		end
		else
		begin
			rst_d1 <= rst_n_i;
			rst_d2 <= rst_d1;
		end
	end

	assign rst_n_int_o = rst_d2;

endmodule

`default_nettype wire

/* sc_frame_builder.sv */
// Builds the CHIP_ID + slow-control frame and writes it byte by byte into the FIFO
`timescale 1ns/10ps
`default_nettype none

module sc_frame_builder (
	input  wire              Clk_Out_2_All,
	input  wire              rst_n_i,
	input  wire              start_i,
	input  wire daq_pkg::sc_cfg_t cfg_i,
	input  wire              done_i,
	input  wire              fifo_full_i,
	output logic             fifo_wr_en_o,
	output logic [7:0]       fifo_data_o,
	output logic             busy_o
);
	import daq_pkg::*;

	logic [SC_BITS-1:0]          frame_q;             // MSB byte goes out first
	logic [$clog2(SC_BYTES)-1:0] byte_cnt;
	logic                        sending;
	logic                        load;

	assign load         = start_i & ~busy_o;
	assign fifo_wr_en_o = sending & ~fifo_full_i;   // Pause while full
	assign fifo_data_o  = frame_q[SC_BITS-1 -: 8];

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			sending  <= 1'b0;
			busy_o   <= 1'b0;
			byte_cnt <= '0;
		end
		else if (load)
		begin
			sending  <= 1'b1;
			busy_o   <= 1'b1;                         // High the cycle after start
			byte_cnt <= '0;
		end
		else
		begin
			if (fifo_wr_en_o)
			begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == SC_BYTES - 1)
					sending <= 1'b0;                    // Last byte written
			end
			if (done_i)
				busy_o <= 1'b0;                         // Shifter finished the last bit
		end
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (load)
			frame_q <= {CHIP_ID, cfg_i};
		else if (fifo_wr_en_o)
			frame_q <= {frame_q[SC_BITS-9:0], 8'h00};   // Next byte to the top
	end

endmodule

`default_nettype wire

/* sc_shifter.sv */
// Pops frame bytes from the FIFO and shifts them MSB first into the ASIC SC register
`timescale 1ns/10ps
`default_nettype none

module sc_shifter (
	input  wire        Clk_Out_2_All,
	input  wire        rst_n_i,
	input  wire        fifo_empty_i,
	input  wire  [7:0] fifo_data_i,
	output logic       fifo_rd_en_o,
	output logic       sr_ck_o,
	output logic       sr_in_o,
	output logic       done_o
);
	import daq_pkg::*;

	logic [7:0]                   sh_byte;
	logic [$clog2(2*SR_HALF)-1:0] phase;            // Position inside one bit
	logic [$clog2(SC_BITS)-1:0]   bit_cnt;
	logic                         loading;          // FIFO data valid this cycle
	logic                         shifting;
	logic                         bit_end;

	assign fifo_rd_en_o = ~loading & ~shifting & ~fifo_empty_i;
	assign bit_end      = shifting & (phase == 2*SR_HALF - 1);

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			loading  <= 1'b0;
			shifting <= 1'b0;
			phase    <= '0;
			bit_cnt  <= '0;
			sr_ck_o  <= 1'b0;
			sr_in_o  <= 1'b0;
			done_o   <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (fifo_rd_en_o)
				loading <= 1'b1;
			else if (loading)
			begin
				loading  <= 1'b0;
				shifting <= 1'b1;
				phase    <= '0;
				sr_in_o  <= fifo_data_i[7];              // First bit of the byte
			end
			else if (shifting)
			begin
				phase <= phase + 1'b1;
				if (phase == SR_HALF - 1)
					sr_ck_o <= 1'b1;                       // Rising edge at mid-bit
				if (bit_end)
				begin
					sr_ck_o <= 1'b0;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == SC_BITS - 1)
					begin
						shifting <= 1'b0;                    // Frame complete
						bit_cnt  <= '0;
						sr_in_o  <= 1'b0;
						done_o   <= 1'b1;
					end
					else if (bit_cnt[2:0] == 3'd7)
						shifting <= 1'b0;                    // Fetch next byte
					else
						sr_in_o <= sh_byte[6];
				end
			end
		end
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (loading)
			sh_byte <= fifo_data_i;
		else if (bit_end)
			sh_byte <= {sh_byte[6:0], 1'b0};
	end

endmodule

`default_nettype wire

/* skiroc_daq.f */
daq_pkg.sv
power_on_reset.sv
cmd_regs.sv
byte_fifo.sv
sc_frame_builder.sv
sc_shifter.sv
hv_cmd_builder.sv
hv_uart_tx.sv
daq_top.sv
tb_clk_gen.sv
daq_tb.sv

/* tb_clk_gen.sv */
// Testbench clock source, 40 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0;                                  // Low at time zero
		forever
			#20 clk_o = ~clk_o;                        // Half of 40 ns
	end

endmodule

`default_nettype wire
